// ==== design/clint_pkg.sv ====
/*
 * Core-local timer definitions.
 * Bus widths, word indices, reset values and the byte-lane merge helper.
 */

package clint_pkg;

    // Bus data word, also the width of every timer register.
    typedef logic [63:0] clint_word_t;

    // Byte-write mask, bit i covers data bits 8i+7 down to 8i.
    typedef logic [7:0]  clint_strb_t;

    // Word index on the bus.
    typedef logic [1:0]  clint_addr_t;

    // Word map.
    localparam clint_addr_t ADDR_MTIME    = 2'd0;
    localparam clint_addr_t ADDR_MTIMECMP = 2'd1;
    localparam clint_addr_t ADDR_MSIP     = 2'd2;
    localparam clint_addr_t ADDR_CTRL     = 2'd3;

    // Default width of the prescale field in the control word.
    localparam int unsigned PRESCALE_W_DEFAULT = 16;

    // All ones keeps the timer interrupt quiet out of reset.
    localparam clint_word_t MTIMECMP_RESET = '1;

    // Control word layout.
    localparam int unsigned CTRL_EN_BIT       = 0;
    localparam int unsigned CTRL_PRESCALE_LSB = 16;

    // Replaces the bytes of old_word whose mask bit is set.
    function automatic clint_word_t byte_merge(
        input clint_word_t old_word,
        input clint_word_t new_word,
        input clint_strb_t strb
    );
        clint_word_t merged;
        merged = old_word;
        for (int i = 0; i < 8; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// ==== design/clint_top.sv ====
/*
 * Core-local timer top level.
 * Register block beside the mtime counter it steers.
 */

module clint_top #(
    parameter int unsigned PRESCALE_W = clint_pkg::PRESCALE_W_DEFAULT
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   en_i,
    input  clint_pkg::clint_addr_t addr_i,
    input  clint_pkg::clint_strb_t we_i,
    input  clint_pkg::clint_word_t data_i,
    output clint_pkg::clint_word_t data_o,
    output logic                   mti_o,
    output logic                   msip_o,
    output clint_pkg::clint_word_t mtime_o
);

    import clint_pkg::*;

    // Register block to counter.
    clint_strb_t           mtime_we;
    clint_word_t           mtime_wdata;
    logic                  count_en;
    logic [PRESCALE_W-1:0] prescale;
    logic                  ctrl_wr;
    clint_word_t           mtimecmp;

    timer_regs #(
        .PRESCALE_W(PRESCALE_W)
    ) u_regs (
        .clk          (clk),
        .reset_n      (reset_n),
        .en_i         (en_i),
        .addr_i       (addr_i),
        .we_i         (we_i),
        .data_i       (data_i),
        .mtime_i      (mtime_o),
        .data_o       (data_o),
        .msip_o       (msip_o),
        .mtimecmp_o   (mtimecmp),
        .mtime_we_o   (mtime_we),
        .mtime_wdata_o(mtime_wdata),
        .count_en_o   (count_en),
        .prescale_o   (prescale),
        .ctrl_wr_o    (ctrl_wr)
    );

    mtime_counter #(
        .PRESCALE_W(PRESCALE_W)
    ) u_counter (
        .clk          (clk),
        .reset_n      (reset_n),
        .mtime_we_i   (mtime_we),
        .mtime_wdata_i(mtime_wdata),
        .count_en_i   (count_en),
        .prescale_i   (prescale),
        .ctrl_wr_i    (ctrl_wr),
        .mtimecmp_i   (mtimecmp),
        .mtime_o      (mtime_o),
        .mti_o        (mti_o)
    );

endmodule

// ==== design/mtime_counter.sv ====
/*
 * Machine timer counter.
 * Prescaled 64-bit mtime with byte-lane load, and the registered
 * mtime >= mtimecmp compare that drives the timer interrupt.
 */

module mtime_counter #(
    parameter int unsigned PRESCALE_W = clint_pkg::PRESCALE_W_DEFAULT
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  clint_pkg::clint_strb_t mtime_we_i,
    input  clint_pkg::clint_word_t mtime_wdata_i,
    input  logic                   count_en_i,
    input  logic [PRESCALE_W-1:0]  prescale_i,
    input  logic                   ctrl_wr_i,
    input  clint_pkg::clint_word_t mtimecmp_i,
    output clint_pkg::clint_word_t mtime_o,
    output logic                   mti_o
);

    import clint_pkg::*;

    // Position inside the current prescale period.
    logic [PRESCALE_W-1:0] phase_q;

    // One-cycle increment request for mtime.
    logic                  tick;

    // Next mtime value after a byte-lane load.
    clint_word_t           mtime_loaded;

    // The last cycle of a period ticks.
    // A control write starts a fresh period, so it never ticks itself.
    assign tick = count_en_i && !ctrl_wr_i && (phase_q == prescale_i);

    assign mtime_loaded = byte_merge(mtime_o, mtime_wdata_i, mtime_we_i);

    // Prescale phase counter.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            phase_q <= '0;
        end
        else if (ctrl_wr_i || tick) begin
            phase_q <= '0;
        end
        else if (count_en_i) begin
            phase_q <= phase_q + 1'b1;
        end
    end

    // mtime itself.
    // A bus load takes priority and swallows a tick in the same cycle.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mtime_o <= '0;
        end
        else if (mtime_we_i != '0) begin
            mtime_o <= mtime_loaded;
        end
        else if (tick) begin
            mtime_o <= mtime_o + 64'd1;
        end
    end

    // Timer interrupt, one cycle behind the registers it compares.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mti_o <= 1'b0;
        end
        else begin
            mti_o <= (mtime_o >= mtimecmp_i);
        end
    end

endmodule

// ==== design/timer_regs.sv ====
/*
 * Timer register block.
 * Decodes the strobe bus, holds mtimecmp, msip and the control word,
 * steers mtime writes to the counter and registers the read data.
 */

module timer_regs #(
    parameter int unsigned PRESCALE_W = clint_pkg::PRESCALE_W_DEFAULT
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   en_i,
    input  clint_pkg::clint_addr_t addr_i,
    input  clint_pkg::clint_strb_t we_i,
    input  clint_pkg::clint_word_t data_i,
    input  clint_pkg::clint_word_t mtime_i,
    output clint_pkg::clint_word_t data_o,
    output logic                   msip_o,
    output clint_pkg::clint_word_t mtimecmp_o,
    output clint_pkg::clint_strb_t mtime_we_o,
    output clint_pkg::clint_word_t mtime_wdata_o,
    output logic                   count_en_o,
    output logic [PRESCALE_W-1:0]  prescale_o,
    output logic                   ctrl_wr_o
);

    import clint_pkg::*;

    // Bus cycle type.
    logic        wr_cycle;
    logic        rd_cycle;

    // Per-word write selects.
    logic        wr_mtime;
    logic        wr_mtimecmp;
    logic        wr_msip;

    // Control word as it reads back, and after a byte-lane write.
    clint_word_t ctrl_word;
    clint_word_t ctrl_next;

    // Read mux output.
    clint_word_t rd_word;

    // An all-zero mask marks a read
    assign wr_cycle = en_i && (we_i != '0);
    assign rd_cycle = en_i && (we_i == '0);

    assign wr_mtime    = wr_cycle && (addr_i == ADDR_MTIME);
    assign wr_mtimecmp = wr_cycle && (addr_i == ADDR_MTIMECMP);
    assign wr_msip     = wr_cycle && (addr_i == ADDR_MSIP);
    assign ctrl_wr_o   = wr_cycle && (addr_i == ADDR_CTRL);

    // mtime lives in the counter; only the mask and data go across.
    assign mtime_we_o    = wr_mtime ? we_i : '0;
    assign mtime_wdata_o = data_i;

    // Rebuild the control word from its fields, other bits read as zero.
    always_comb begin
        ctrl_word = '0;
        ctrl_word[CTRL_EN_BIT] = count_en_o;
        ctrl_word[CTRL_PRESCALE_LSB +: PRESCALE_W] = prescale_o;
    end

    assign ctrl_next = byte_merge(ctrl_word, data_i, we_i);

    // mtimecmp.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mtimecmp_o <= MTIMECMP_RESET;
        end
        else if (wr_mtimecmp) begin
            mtimecmp_o <= byte_merge(mtimecmp_o, data_i, we_i);
        end
    end

    // msip, only bit 0 is kept.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            msip_o <= 1'b0;
        end
        else if (wr_msip && we_i[0]) begin
            msip_o <= data_i[0];
        end
    end

    // Control fields.
    // Counting is on out of reset so mtime free-runs by default.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count_en_o <= 1'b1;
            prescale_o <= '0;
        end
        else if (ctrl_wr_o) begin
            count_en_o <= ctrl_next[CTRL_EN_BIT];
            prescale_o <= ctrl_next[CTRL_PRESCALE_LSB +: PRESCALE_W];
        end
    end

    // Read mux.
    always_comb begin
        case (addr_i)
            ADDR_MTIME: begin
                rd_word = mtime_i;
            end
            ADDR_MTIMECMP: begin
                rd_word = mtimecmp_o;
            end
            ADDR_MSIP: begin
                rd_word = {63'd0, msip_o};
            end
            default: begin
                rd_word = ctrl_word;
            end
        endcase
    end

    // Read data register.
    // Holds the last read word; writes leave it alone.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_o <= '0;
        end
        else if (rd_cycle) begin
            data_o <= rd_word;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compiles and runs the core-local timer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=clint_sim

verilator --binary --assert -f sim.f --top-module clint_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$("./$BUILD_DIR/$SIM_BIN")
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit 1
fi

if echo "$output" | grep -Fxq "Simulation completed successfully"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// ==== sim.f ====
+incdir+test
design/clint_pkg.sv
design/mtime_counter.sv
design/timer_regs.sv
design/clint_top.sv
test/clint_properties.sv
test/clint_tb.sv

// ==== test/clint_properties.sv ====
/*
 * Bound checks on the timer top level.
 * Timer interrupt timing, read data stability and known interrupt lines.
 */

module clint_properties (
    input logic                   clk,
    input logic                   reset_n,
    input logic                   en_i,
    input clint_pkg::clint_strb_t we_i,
    input clint_pkg::clint_word_t read_data_i,
    input clint_pkg::clint_word_t mtime_i,
    input clint_pkg::clint_word_t mtimecmp_i,
    input logic                   mti_i,
    input logic                   msip_i
);

    // The timer interrupt is the compare of the previous cycle.
    mti_follows_compare: assert property (
        @(posedge clk) disable iff (!reset_n)
        mti_i == $past(mtime_i >= mtimecmp_i)
    ) else $error("mti_o differs from the previous cycle's mtime >= mtimecmp");

    // Read data moves only after a read cycle.
    read_data_holds: assert property (
        @(posedge clk) disable iff (!reset_n)
        !$stable(read_data_i) |-> $past(en_i && (we_i == '0))
    ) else $error("data_o changed without a read in the previous cycle");

    // Interrupt lines always driven.
    irq_known: assert property (
        @(posedge clk) disable iff (!reset_n)
        !$isunknown({mti_i, msip_i})
    ) else $error("mti_o or msip_o is unknown after reset");

endmodule

bind clint_top clint_properties u_props (
    .clk        (clk),
    .reset_n    (reset_n),
    .en_i       (en_i),
    .we_i       (we_i),
    .read_data_i(data_o),
    .mtime_i    (mtime_o),
    .mtimecmp_i (mtimecmp),
    .mti_i      (mti_o),
    .msip_i     (msip_o)
);

// ==== test/clint_tests.svh ====
/*
 * Directed tests for the core-local timer and the bus helpers they use.
 */

// Advances to just after the next rising edge, where inputs are driven.
task automatic wait_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
endtask

task automatic write_word(input clint_addr_t addr, input clint_strb_t strb,
                          input clint_word_t data);
    en_i   = 1'b1;
    addr_i = addr;
    we_i   = strb;
    data_i = data;
    wait_cycle();
    en_i = 1'b0;
    we_i = '0;
endtask

task automatic read_word(input clint_addr_t addr, output clint_word_t data);
    en_i   = 1'b1;
    addr_i = addr;
    we_i   = '0;
    wait_cycle();
    en_i = 1'b0;
    data = data_o;
endtask

task automatic check_value(input string what, input clint_word_t got,
                           input clint_word_t expected);
    if (got !== expected) begin
        $display("Mismatch at time %0t: %s, expected %h, got %h", $time, what, expected, got);
        mismatch_count++;
    end
endtask

// Expands a byte mask to one bit per data bit.
function automatic clint_word_t lane_bits(input clint_strb_t strb);
    return {{8{strb[7]}}, {8{strb[6]}}, {8{strb[5]}}, {8{strb[4]}},
            {8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
endfunction

task automatic test_reset_state();
    clint_word_t rd;
    check_value("data_o after reset", data_o, 64'd0);
    check_value("mti_o after reset", 64'(mti_o), 64'd0);
    check_value("msip_o after reset", 64'(msip_o), 64'd0);
    read_word(ADDR_MTIMECMP, rd);
    check_value("mtimecmp after reset", rd, {64{1'b1}});
    read_word(ADDR_CTRL, rd);
    check_value("ctrl after reset", rd, 64'd1);
    read_word(ADDR_MSIP, rd);
    check_value("msip after reset", rd, 64'd0);
endtask

// One random byte-lane write to a word and a read back.
task automatic lane_round(input clint_addr_t addr);
    clint_word_t wdata;
    clint_word_t lanes;
    clint_word_t expected;
    clint_word_t rd;
    clint_strb_t strb;
    wdata = {$urandom(), $urandom()};
    strb  = 8'($urandom());
    if (strb == 8'd0) begin
        strb = 8'h01;
    end
    lanes = lane_bits(strb);
    write_word(addr, strb, wdata);
    case (addr)
        ADDR_MTIMECMP: begin
            model_mtimecmp = (model_mtimecmp & ~lanes) | (wdata & lanes);
            expected = model_mtimecmp;
        end
        ADDR_MSIP: begin
            if (strb[0]) begin
                model_msip = wdata[0];
            end
            expected = {63'd0, model_msip};
        end
        default: begin
            model_ctrl = ((model_ctrl & ~lanes) | (wdata & lanes)) & CTRL_MASK;
            expected = model_ctrl;
        end
    endcase
    read_word(addr, rd);
    check_value($sformatf("word %0d after write with mask %h", addr, strb), rd, expected);
    check_value("msip_o against model", 64'(msip_o), 64'(model_msip));
endtask

task automatic test_byte_lanes();
    int unsigned round;
    for (round = 0; round < LANE_ROUNDS; round++) begin
        lane_round(ADDR_MTIMECMP);
        lane_round(ADDR_MSIP);
        lane_round(ADDR_CTRL);
    end
endtask

task automatic test_counting(input int unsigned prescale);
    clint_word_t rd;
    clint_word_t expected;
    int unsigned edges;
    model_ctrl = 64'd0;
    write_word(ADDR_CTRL, 8'hFF, model_ctrl);
    model_mtime = {$urandom(), $urandom()};
    write_word(ADDR_MTIME, 8'hFF, model_mtime);
    wait_cycle();
    read_word(ADDR_MTIME, rd);
    check_value("mtime read back while stopped", rd, model_mtime);

    model_ctrl = (64'(prescale) << CTRL_PRESCALE_LSB) | 64'd1;
    write_word(ADDR_CTRL, 8'hFF, model_ctrl);
    // One increment every prescale+1 edges counted from the ctrl write.
    expected = model_mtime;
    for (edges = 1; edges <= COUNT_TICKS * (prescale + 1); edges++) begin
        wait_cycle();
        expected = model_mtime + 64'(edges / (prescale + 1));
        check_value($sformatf("mtime %0d edges after enable, prescale %0d", edges, prescale),
                    mtime_o, expected);
    end
    model_mtime = expected;
endtask

task automatic test_timer_interrupt();
    clint_word_t rd;
    int unsigned waited;
    model_ctrl = 64'd0;
    write_word(ADDR_CTRL, 8'hFF, model_ctrl);
    model_mtime = {32'd0, $urandom()};
    write_word(ADDR_MTIME, 8'hFF, model_mtime);
    model_mtimecmp = model_mtime + 64'd5;
    write_word(ADDR_MTIMECMP, 8'hFF, model_mtimecmp);
    wait_cycle();
    wait_cycle();
    check_value("mti_o while stopped below mtimecmp", 64'(mti_o), 64'd0);

    model_ctrl = 64'd1;
    write_word(ADDR_CTRL, 8'hFF, model_ctrl);
    waited = 0;
    while (mtime_o < model_mtimecmp && waited < REACH_LIMIT) begin
        check_value("mti_o before mtime reaches mtimecmp", 64'(mti_o), 64'd0);
        wait_cycle();
        waited++;
    end
    if (mtime_o < model_mtimecmp) begin
        $display("Timer test: mtime did not reach mtimecmp within %0d cycles", REACH_LIMIT);
        failure_count++;
    end
    else begin
        check_value("mti_o in the cycle mtime reaches mtimecmp", 64'(mti_o), 64'd0);
        wait_cycle();
        check_value("mti_o one cycle after mtime reaches mtimecmp", 64'(mti_o), 64'd1);
        model_mtimecmp = model_mtimecmp + 64'd1000;
        write_word(ADDR_MTIMECMP, 8'hFF, model_mtimecmp);
        check_value("mti_o at the edge mtimecmp is raised", 64'(mti_o), 64'd1);
        wait_cycle();
        check_value("mti_o one cycle after mtimecmp is raised", 64'(mti_o), 64'd0);
        read_word(ADDR_MTIMECMP, rd);
        check_value("mtimecmp after raise", rd, model_mtimecmp);
    end
endtask

task automatic test_software_interrupt();
    clint_word_t rd;
    write_word(ADDR_MSIP, 8'h01, 64'd1);
    check_value("msip_o after setting bit 0", 64'(msip_o), 64'd1);
    write_word(ADDR_MSIP, 8'hFE, 64'd0);
    check_value("msip_o after write without lane 0", 64'(msip_o), 64'd1);
    read_word(ADDR_MSIP, rd);
    check_value("msip read while set", rd, 64'd1);
    write_word(ADDR_MSIP, 8'h01, 64'd0);
    check_value("msip_o after clearing bit 0", 64'(msip_o), 64'd0);
    write_word(ADDR_MSIP, 8'hFE, {64{1'b1}});
    check_value("msip_o after ones without lane 0", 64'(msip_o), 64'd0);
    read_word(ADDR_MSIP, rd);
    check_value("msip read while clear", rd, 64'd0);
    model_msip = 1'b0;
endtask

task automatic test_mtime_carry();
    clint_word_t rd;
    model_ctrl = 64'd0;
    write_word(ADDR_CTRL, 8'hFF, model_ctrl);
    model_mtime = 64'h0000_0000_FFFF_FFFE;
    write_word(ADDR_MTIME, 8'hFF, model_mtime);
    model_ctrl = 64'd1;
    write_word(ADDR_CTRL, 8'hFF, model_ctrl);
    wait_cycle();
    check_value("mtime below the carry", mtime_o, 64'h0000_0000_FFFF_FFFF);
    wait_cycle();
    check_value("mtime after carry into upper half", mtime_o, 64'h0000_0001_0000_0000);
    // The read returns the value from before its own edge.
    read_word(ADDR_MTIME, rd);
    check_value("mtime read after carry", rd, 64'h0000_0001_0000_0000);
endtask

// ==== test/clint_tb.sv ====
/*
 * Testbench for the core-local timer.
 * Clock, reset, watchdog, reference model of the four words and the result.
 */

module clint_tb;

    import clint_pkg::*;

    localparam int unsigned PRESCALE_W   = PRESCALE_W_DEFAULT;
    localparam int unsigned CLK_PERIOD   = 100;
    localparam int unsigned DRIVE_DELAY  = 10;
    localparam int unsigned RESET_CYCLES = 10;
    localparam int unsigned RANDOM_SEED  = 52356;
    localparam int unsigned LANE_ROUNDS  = 8;
    localparam int unsigned COUNT_TICKS  = 4;
    localparam int unsigned REACH_LIMIT  = 20;

    // Cycle budget of each test.
    localparam int unsigned CYC_RESET  = 6;
    localparam int unsigned CYC_LANES  = 3 * LANE_ROUNDS * 2;
    localparam int unsigned CYC_COUNT  = 2 * 8 + COUNT_TICKS * (1 + 4);
    localparam int unsigned CYC_TIMER  = 12 + REACH_LIMIT;
    localparam int unsigned CYC_MSIP   = 12;
    localparam int unsigned CYC_CARRY  = 10;
    localparam int unsigned CYC_MARGIN = 100;
    localparam int unsigned WATCHDOG_CYCLES = RESET_CYCLES + CYC_RESET + CYC_LANES
        + CYC_COUNT + CYC_TIMER + CYC_MSIP + CYC_CARRY + CYC_MARGIN;

    // Bits of the control word that hold state.
    localparam clint_word_t CTRL_MASK = (64'd1 << CTRL_EN_BIT)
        | (((64'd1 << PRESCALE_W) - 64'd1) << CTRL_PRESCALE_LSB);

    logic        clk;
    logic        reset_n;
    logic        en_i;
    clint_addr_t addr_i;
    clint_strb_t we_i;
    clint_word_t data_i;
    clint_word_t data_o;
    logic        mti_o;
    logic        msip_o;
    clint_word_t mtime_o;

    // Reference model of the four words.
    clint_word_t model_mtime;
    clint_word_t model_mtimecmp;
    clint_word_t model_ctrl;
    logic        model_msip;

    int unsigned mismatch_count;
    int unsigned failure_count;

    clint_top #(
        .PRESCALE_W(PRESCALE_W)
    ) UUT (
        .clk    (clk),
        .reset_n(reset_n),
        .en_i   (en_i),
        .addr_i (addr_i),
        .we_i   (we_i),
        .data_i (data_i),
        .data_o (data_o),
        .mti_o  (mti_o),
        .msip_o (msip_o),
        .mtime_o(mtime_o)
    );

    `include "clint_tests.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(RANDOM_SEED));
        reset_n        = 1'b0;
        en_i           = 1'b0;
        addr_i         = '0;
        we_i           = '0;
        data_i         = '0;
        mismatch_count = 0;
        failure_count  = 0;
        // The model starts from the reset values of the four words.
        model_mtime    = 64'd0;
        model_mtimecmp = {64{1'b1}};
        model_ctrl     = 64'd1;
        model_msip     = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset_n = 1'b1;

        test_reset_state();
        test_byte_lanes();
        test_counting(0);
        test_counting(3);
        test_timer_interrupt();
        test_software_interrupt();
        test_mtime_carry();

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Simulation completed successfully");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
